// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= pat_tb
FILELIST  ?= pat.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/pat.sv ====
`timescale 1ns/10ps

module pat
(
	input logic clk,
	input logic reset,
	input logic [pat_pkg::I_WIDTH-1:0] i_instruction,
	input pat_pkg::word_t i_field_in,
	input pat_pkg::word_t i_inputs,
	output pat_pkg::pc_t o_pc,
	output pat_pkg::fieldp_t o_fieldp,
	output pat_pkg::fieldp_t o_fieldwp,
	output logic o_field_write_en,
	output pat_pkg::word_t o_field_out,
	output pat_pkg::word_t o_acc,
	output pat_pkg::word_t o_outputs
);
	import pat_pkg::*;

	ctrl_t ctrl; // stage 2 control to both lanes and memory
	logic [D_ADR_WIDTH-1:0] mem_radr;
	word_t mem_rdata;
	logic branch_fwd;
	logic branch_back;
	logic [7:0] branch_offset;
	fieldp_t fieldp_next;
	word_t field_value; // latched field_in for stores

	// ====================
	// stage 1
	// ====================
	pat_decode u_decode
	(
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.i_mem_rdata(mem_rdata),
		.o_mem_radr(mem_radr),
		.o_ctrl(ctrl),
		.o_branch_fwd(branch_fwd),
		.o_branch_back(branch_back),
		.o_branch_offset(branch_offset),
		.o_fieldp_next(fieldp_next)
	);

	pat_pc u_pc
	(
		.clk(clk),
		.reset(reset),
		.i_branch_fwd(branch_fwd),
		.i_branch_back(branch_back),
		.i_branch_offset(branch_offset),
		.o_pc(o_pc)
	);

	// ====================
	// stage 2 lanes
	// ====================
	pat_acc_lane u_acc_lane
	(
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_inputs(i_inputs),
		.o_acc(o_acc),
		.o_outputs(o_outputs)
	);

	pat_field_lane u_field_lane
	(
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_field_in(i_field_in),
		.i_inputs(i_inputs),
		.i_fieldp_next(fieldp_next),
		.o_field_out(o_field_out),
		.o_field_write_en(o_field_write_en),
		.o_field_value(field_value),
		.o_fieldp(o_fieldp),
		.o_fieldwp(o_fieldwp)
	);

	// lanes meet here
	pat_data_mem u_data_mem
	(
		.clk(clk),
		.i_ctrl(ctrl),
		.i_acc(o_acc),
		.i_field_value(field_value),
		.i_radr(mem_radr),
		.o_rdata(mem_rdata)
	);

endmodule

// ==== design/pat_acc_lane.sv ====
`timescale 1ns/10ps

module pat_acc_lane
(
	input logic clk,
	input logic reset,
	input pat_pkg::ctrl_t i_ctrl,
	input pat_pkg::word_t i_inputs,
	output pat_pkg::word_t o_acc,
	output pat_pkg::word_t o_outputs
);
	import pat_pkg::*;

	word_t acc_y; // alu result for this lane

	// acc is always operand a here
	pat_alu u_acc_alu
	(
		.i_a(o_acc),
		.i_b(i_ctrl.operand_b),
		.i_inputs(i_inputs),
		.i_op(i_ctrl.alu_op),
		.o_y(acc_y)
	);

	// ====================
	// commit at edge k+2
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			o_outputs <= '0;
		end
		else
		begin
			if (i_ctrl.dest_acc)
				o_acc <= acc_y;
			if (i_ctrl.out_en)
				o_outputs <= o_acc; // acc as left by previous op
		end
	end

endmodule

// ==== design/pat_alu.sv ====
`timescale 1ns/10ps

module pat_alu
(
	input pat_pkg::word_t i_a,
	input pat_pkg::word_t i_b,
	input pat_pkg::word_t i_inputs,
	input pat_pkg::alu_op_e i_op,
	output pat_pkg::word_t o_y
);
	import pat_pkg::*;

	logic sub; // inverts b and sets carry in
	word_t b_addend;
	word_t sum;
	logic [2:0] shamt;

	// ====================
	// one adder for add and sub
	// ====================
	assign sub = (i_op == ALU_SUB);
	assign b_addend = sub ? ~i_b : i_b;
	assign sum = i_a + b_addend + word_t'(sub);

	assign shamt = i_b[2:0]; // low bits only

	always_comb
	begin
		case (i_op)
			ALU_OR: o_y = i_a | i_b;
			ALU_AND: o_y = i_a & i_b;
			ALU_NOT: o_y = ~i_a;
			ALU_ADD, ALU_SUB: o_y = sum;
			ALU_SHL: o_y = i_a << shamt;
			ALU_SHR: o_y = i_a >> shamt;
			ALU_ASR: o_y = word_t'($signed(i_a) >>> shamt); // sign fill
			ALU_PASS_B: o_y = i_b; // ldi, ldm
			ALU_PASS_IN: o_y = i_inputs;
			default: o_y = i_b;
		endcase
	end

endmodule

// ==== design/pat_data_mem.sv ====
`timescale 1ns/10ps

module pat_data_mem
(
	input logic clk,
	input pat_pkg::ctrl_t i_ctrl,
	input pat_pkg::word_t i_acc,
	input pat_pkg::word_t i_field_value,
	input logic [pat_pkg::D_ADR_WIDTH-1:0] i_radr,
	output pat_pkg::word_t o_rdata
);
	import pat_pkg::*;

	word_t mem [DMEM_SIZE]; // 32 words, address mod 32
	word_t wdata;
	logic [DMEM_IDX_WIDTH-1:0] widx;
	logic [DMEM_IDX_WIDTH-1:0] ridx;

	// store source picked from one of the two lanes
	assign wdata = i_ctrl.store_from_field ? i_field_value : i_acc;
	assign widx = i_ctrl.store_adr[DMEM_IDX_WIDTH-1:0];
	assign ridx = i_radr[DMEM_IDX_WIDTH-1:0];

	// write at edge k+2
	always_ff @(posedge clk)
	begin
		if (i_ctrl.store)
			mem[widx] <= wdata;
	end

	// async read during stage 1
	assign o_rdata = mem[ridx];

endmodule

// ==== design/pat_decode.sv ====
`timescale 1ns/10ps

module pat_decode
(
	input logic clk,
	input logic reset,
	input logic [pat_pkg::I_WIDTH-1:0] i_instruction,
	input pat_pkg::word_t i_mem_rdata,
	output logic [pat_pkg::D_ADR_WIDTH-1:0] o_mem_radr,
	output pat_pkg::ctrl_t o_ctrl,
	output logic o_branch_fwd,
	output logic o_branch_back,
	output logic [7:0] o_branch_offset,
	output pat_pkg::fieldp_t o_fieldp_next
);
	import pat_pkg::*;

	logic [I_WIDTH-1:0] instr_q; // stage 1 instruction
	op_i8_e opc8;
	op_i3_e opc3;
	op_i0_e opc0;
	logic [7:0] imm8;
	word_t imm3_ext;
	word_t imm_sel; // immediate of whichever space decoded
	logic field_op;
	logic is_i8;
	logic is_i3;
	logic use_mem; // b operand from data memory
	logic dest_reg; // op writes acc or field_out
	alu_op_e alu_op;
	ctrl_t ctrl_d;

	always_ff @(posedge clk)
	begin
		if (reset)
			instr_q <= NOP_INSTR;
		else
			instr_q <= i_instruction; // edge k
	end

	// ====================
	// field split
	// ====================
	assign opc8 = op_i8_e'(instr_q[OPC8_MSB:OPC8_LSB]);
	assign opc3 = op_i3_e'(instr_q[OPC3_MSB:OPC3_LSB]);
	assign opc0 = op_i0_e'(instr_q[OPC0_MSB:OPC0_LSB]);
	assign imm8 = instr_q[IMM8_MSB:IMM8_LSB];
	assign imm3_ext = word_t'(instr_q[IMM3_MSB:IMM3_LSB]); // zero extended
	assign field_op = instr_q[FIELD_OP_BIT];

	// prefix escapes pick the opcode space
	assign is_i8 = (opc8 != OP8_I3);
	assign is_i3 = !is_i8 && (opc3 != OP3_I0);

	assign use_mem = is_i8 && (opc8 inside {OP8_ADDM, OP8_SUBM, OP8_ORM, OP8_ANDM, OP8_LDM});
	assign imm_sel = is_i8 ? imm8 : imm3_ext;

	// alu function and whether a register is written
	always_comb
	begin
		alu_op = ALU_PASS_B;
		dest_reg = 1'b1;
		if (is_i8)
		begin
			case (opc8)
				OP8_OR, OP8_ORM: alu_op = ALU_OR;
				OP8_AND, OP8_ANDM: alu_op = ALU_AND;
				OP8_ADD, OP8_ADDM: alu_op = ALU_ADD;
				OP8_SUB, OP8_SUBM: alu_op = ALU_SUB;
				OP8_LDI, OP8_LDM: alu_op = ALU_PASS_B; // b already muxed
				default: dest_reg = 1'b0; // branches, stam, codes 10 and 12
			endcase
		end
		else if (is_i3)
		begin
			case (opc3)
				OP3_SHL, OP3_SHLO: alu_op = ALU_SHL; // shlo same as shl
				OP3_SHR: alu_op = ALU_SHR;
				OP3_ASR: alu_op = ALU_ASR;
				OP3_IN: alu_op = ALU_PASS_IN;
				default: dest_reg = 1'b0; // out and unused codes
			endcase
		end
		else
		begin
			alu_op = ALU_NOT;
			dest_reg = (opc0 == OP0_NOT); // everything else is nop
		end
	end

	always_comb
	begin
		ctrl_d.alu_op = alu_op;
		ctrl_d.dest_acc = dest_reg && !field_op;
		ctrl_d.dest_field = dest_reg && field_op;
		ctrl_d.store = is_i8 && (opc8 == OP8_STAM);
		ctrl_d.store_from_field = field_op;
		ctrl_d.out_en = is_i3 && (opc3 == OP3_OUT);
		ctrl_d.operand_b = use_mem ? i_mem_rdata : imm_sel; // async mem read
		ctrl_d.store_adr = imm8;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			o_ctrl <= '0; // no dest, no store, acts as nop
		else
			o_ctrl <= ctrl_d; // edge k+1
	end

	assign o_mem_radr = imm8;
	assign o_branch_fwd = is_i8 && (opc8 == OP8_BF);
	assign o_branch_back = is_i8 && (opc8 == OP8_BB);
	assign o_branch_offset = imm8;
	assign o_fieldp_next = instr_q[FIELDP_MSB:FIELDP_LSB];

endmodule

// ==== design/pat_field_lane.sv ====
`timescale 1ns/10ps

module pat_field_lane
(
	input logic clk,
	input logic reset,
	input pat_pkg::ctrl_t i_ctrl,
	input pat_pkg::word_t i_field_in,
	input pat_pkg::word_t i_inputs,
	input pat_pkg::fieldp_t i_fieldp_next,
	output pat_pkg::word_t o_field_out,
	output logic o_field_write_en,
	output pat_pkg::word_t o_field_value,
	output pat_pkg::fieldp_t o_fieldp,
	output pat_pkg::fieldp_t o_fieldwp
);
	import pat_pkg::*;

	word_t field_y;
	fieldp_t [FIELD_LATENCY-1:0] fieldp_hist; // [0] newest

	// live field word is operand a
	pat_alu u_field_alu
	(
		.i_a(i_field_in),
		.i_b(i_ctrl.operand_b),
		.i_inputs(i_inputs),
		.i_op(i_ctrl.alu_op),
		.o_y(field_y)
	);

	// ====================
	// pointers and strobe
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_field_write_en <= 1'b0;
			o_fieldp <= '0;
			fieldp_hist <= '0;
		end
		else
		begin
			o_field_write_en <= i_ctrl.dest_field; // one cycle per field op
			o_fieldp <= i_fieldp_next; // edge k+1
			fieldp_hist <= {fieldp_hist[FIELD_LATENCY-2:0], o_fieldp};
		end
	end

	assign o_fieldwp = fieldp_hist[FIELD_LATENCY-1]; // fieldp from 4 edges back

	// payload
	always_ff @(posedge clk)
	begin
		o_field_value <= i_field_in; // latched every cycle, feeds stores
		if (i_ctrl.dest_field)
			o_field_out <= field_y;
	end

endmodule

// ==== design/pat_pc.sv ====
`timescale 1ns/10ps

module pat_pc
(
	input logic clk,
	input logic reset,
	input logic i_branch_fwd,
	input logic i_branch_back,
	input logic [7:0] i_branch_offset,
	output pat_pkg::pc_t o_pc
);
	import pat_pkg::*;

	pc_t offset; // zero extended branch distance
	pc_t pc_next;

	assign offset = pc_t'(i_branch_offset);

	// all three wrap mod 1024 by width
	always_comb
	begin
		if (i_branch_fwd)
			pc_next = o_pc + offset;
		else if (i_branch_back)
			pc_next = o_pc - offset;
		else
			pc_next = o_pc + pc_t'(1);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else
			o_pc <= pc_next; // branch lands at edge k+1
	end

endmodule

// ==== design/pat_pkg.sv ====
package pat_pkg;

	// ====================
	// widths and sizes
	// ====================
	localparam int I_WIDTH = 20; // instruction word
	localparam int I_ADR_WIDTH = 10; // program space, wraps at 1024
	localparam int D_WIDTH = 8; // data, field and port width
	localparam int D_ADR_WIDTH = 8;
	localparam int DMEM_SIZE = 32; // words actually built
	localparam int DMEM_IDX_WIDTH = $clog2(DMEM_SIZE); // low address bits used
	localparam int FIELDP_WIDTH = 5;
	localparam int FIELD_LATENCY = 4; // field read to matching write pointer
	localparam logic [3:0] OPC_PREFIX = 4'b1111; // escape into next opcode space

	// ====================
	// instruction fields
	// ====================
	localparam int RSV_MSB = 14; // reserved, old condition field
	localparam int RSV_LSB = 13;
	localparam int FIELDP_MSB = I_WIDTH - 1;
	localparam int FIELDP_LSB = RSV_MSB + 1;
	localparam int FIELD_OP_BIT = RSV_LSB - 1; // 1 routes result to field lane
	localparam int OPC8_MSB = 11;
	localparam int OPC8_LSB = 8;
	localparam int IMM8_MSB = 7;
	localparam int IMM8_LSB = 0;
	localparam int OPC3_MSB = 7; // sits inside imm8
	localparam int OPC3_LSB = 4;
	localparam int IMM3_MSB = 2;
	localparam int IMM3_LSB = 0;
	localparam int OPC0_MSB = 3;
	localparam int OPC0_LSB = 0;

	// all three opcode spaces escaped, i0 nop
	localparam logic [I_WIDTH-1:0] NOP_INSTR = 20'h00fff;

	typedef logic [D_WIDTH-1:0] word_t;
	typedef logic [I_ADR_WIDTH-1:0] pc_t;
	typedef logic [FIELDP_WIDTH-1:0] fieldp_t;

	// i8 space
	typedef enum logic [3:0] {
		OP8_OR = 4'd0,
		OP8_AND = 4'd1,
		OP8_ADDM = 4'd2,
		OP8_SUBM = 4'd3,
		OP8_ADD = 4'd4,
		OP8_SUB = 4'd5,
		OP8_LDI = 4'd6,
		OP8_LDM = 4'd7,
		OP8_BF = 4'd8,
		OP8_BB = 4'd9,
		OP8_STAM = 4'd11,
		OP8_ORM = 4'd13,
		OP8_ANDM = 4'd14,
		OP8_I3 = OPC_PREFIX
	} op_i8_e;

	// i3 space
	typedef enum logic [3:0] {
		OP3_SHL = 4'd0,
		OP3_SHLO = 4'd1,
		OP3_SHR = 4'd2,
		OP3_ASR = 4'd3,
		OP3_IN = 4'd5,
		OP3_OUT = 4'd8,
		OP3_I0 = OPC_PREFIX
	} op_i3_e;

	// i0 space
	typedef enum logic [3:0] {
		OP0_NOT = 4'd0,
		OP0_NOP = 4'd15
	} op_i0_e;

	typedef enum logic [3:0] {
		ALU_OR,
		ALU_AND,
		ALU_NOT,
		ALU_ADD,
		ALU_SUB,
		ALU_SHL,
		ALU_SHR,
		ALU_ASR,
		ALU_PASS_B,
		ALU_PASS_IN
	} alu_op_e;

	// stage 2 control, shared by both lanes and the data memory
	typedef struct packed {
		alu_op_e alu_op;
		logic dest_acc; // commit to accumulator
		logic dest_field; // commit to field_out
		logic store; // memory write
		logic store_from_field; // store latched field value, else acc
		logic out_en; // acc to output port
		word_t operand_b; // mem word or immediate
		logic [D_ADR_WIDTH-1:0] store_adr;
	} ctrl_t;

endpackage

// ==== pat.f ====
design/pat_pkg.sv
design/pat_alu.sv
design/pat_decode.sv
design/pat_pc.sv
design/pat_acc_lane.sv
design/pat_field_lane.sv
design/pat_data_mem.sv
design/pat.sv
testbench/pat_chk.sv
testbench/pat_tb.sv

// ==== testbench/pat_chk.sv ====
`timescale 1ns/10ps

module pat_chk
(
	input logic clk,
	input logic reset,
	input logic [pat_pkg::I_WIDTH-1:0] i_instruction,
	input logic i_branch_fwd,
	input logic i_branch_back,
	input pat_pkg::pc_t i_pc,
	input logic i_field_write_en,
	input pat_pkg::word_t i_acc,
	input pat_pkg::word_t i_outputs
);
	import pat_pkg::*;

	// ====================
	// reset values
	// ====================
	assert property (@(posedge clk) reset |=>
		(!i_field_write_en && i_acc == '0 && i_outputs == '0 && i_pc == '0))
	else $error("outputs not cleared by reset");

	// back to back strobes only from back to back field ops
	// strobe is seen three edges after its instruction
	assert property (@(posedge clk) disable iff (reset)
		(i_field_write_en && $past(i_field_write_en)) |->
		($past(i_instruction[FIELD_OP_BIT], 3) && $past(i_instruction[FIELD_OP_BIT], 4)))
	else $error("field write strobe held without field ops");

	// plain step
	assert property (@(posedge clk) disable iff (reset)
		(!i_branch_fwd && !i_branch_back) |=> (i_pc == pc_t'($past(i_pc) + pc_t'(1))))
	else $error("pc did not step by one");

endmodule

bind pat pat_chk u_chk
(
	.clk(clk),
	.reset(reset),
	.i_instruction(i_instruction),
	.i_branch_fwd(branch_fwd),
	.i_branch_back(branch_back),
	.i_pc(o_pc),
	.i_field_write_en(o_field_write_en),
	.i_acc(o_acc),
	.i_outputs(o_outputs)
);

// ==== testbench/pat_tb.sv ====
`timescale 1ns/10ps

module pat_tb;
	import pat_pkg::*;

	localparam int PERIOD = 4; // ns
	localparam int RESET_CYCLES = 16;
	localparam int N_TESTS = 5;

	// expected state after one instruction
	typedef struct packed {
		word_t acc;
		word_t outp;
		word_t fout;
		logic we;
		pc_t pc;
	} expect_t;

	// one reference result
	typedef struct packed {
		logic wr;
		word_t val;
	} result_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [I_WIDTH-1:0] i_instruction;
	word_t i_field_in;
	word_t i_inputs;
	pc_t o_pc;
	fieldp_t o_fieldp;
	fieldp_t o_fieldwp;
	logic o_field_write_en;
	word_t o_field_out;
	word_t o_acc;
	word_t o_outputs;

	logic [31:0] seed;
	logic [I_WIDTH-1:0] prog[$]; // instruction stream
	int tst[$]; // test index per instruction
	word_t fin[$];
	word_t inp[$];
	expect_t exp_q[$];
	int n_instr = 0;
	int cur_test = 0;
	int errors = 0;
	int checks = 0;
	int test_err[N_TESTS];
	logic built = 1'b0;
	logic started = 1'b0;
	string tname[N_TESTS] = '{"alu_random", "mem_ops", "field_ops", "out_port", "branch"};

	pat DUT
	(
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.i_field_in(i_field_in),
		.i_inputs(i_inputs),
		.o_pc(o_pc),
		.o_fieldp(o_fieldp),
		.o_fieldwp(o_fieldwp),
		.o_field_write_en(o_field_write_en),
		.o_field_out(o_field_out),
		.o_acc(o_acc),
		.o_outputs(o_outputs)
	);

	initial
	begin
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		next_random = $random(seed);
	endfunction

	// random field pointer, reserved bits zero
	function automatic logic [I_WIDTH-1:0] encode_instr(logic fop, logic [3:0] opc8,
		logic [7:0] imm8);
		logic [31:0] r;
		r = next_random();
		encode_instr = {r[4:0], 2'b00, fop, opc8, imm8};
	endfunction

	task automatic push_instr(logic [I_WIDTH-1:0] ins);
		prog.push_back(ins);
		tst.push_back(cur_test);
	endtask

	task automatic push_nop();
		push_instr(encode_instr(1'b0, 4'hf, 8'hff));
	endtask

	// random register op, acc or field lane
	task automatic push_alu(logic fop);
		logic [31:0] r;
		int k;
		r = next_random();
		k = int'(r[7:0]) % 11;
		case (k)
			0: push_instr(encode_instr(fop, 4'd6, r[15:8])); // ldi
			1: push_instr(encode_instr(fop, 4'd4, r[15:8]));
			2: push_instr(encode_instr(fop, 4'd5, r[15:8]));
			3: push_instr(encode_instr(fop, 4'd0, r[15:8]));
			4: push_instr(encode_instr(fop, 4'd1, r[15:8]));
			5: push_instr(encode_instr(fop, 4'hf, 8'hf0)); // not
			6: push_instr(encode_instr(fop, 4'hf, {4'd0, 1'b0, r[10:8]}));
			7: push_instr(encode_instr(fop, 4'hf, {4'd1, 1'b0, r[10:8]}));
			8: push_instr(encode_instr(fop, 4'hf, {4'd2, 1'b0, r[10:8]}));
			9: push_instr(encode_instr(fop, 4'hf, {4'd3, 1'b0, r[10:8]}));
			default: push_instr(encode_instr(fop, 4'hf, 8'h50)); // in
		endcase
	endtask

	// ldm, addm, subm, orm or andm at a random address
	task automatic push_memop(logic fop);
		logic [31:0] r;
		logic [3:0] codes[5];
		codes = '{4'd7, 4'd2, 4'd3, 4'd13, 4'd14};
		r = next_random();
		push_instr(encode_instr(fop, codes[int'(r[7:0]) % 5], r[15:8]));
	endtask

	// ====================
	// reference model
	// ====================
	function automatic result_t ref_result(logic [I_WIDTH-1:0] ins, word_t a, word_t m,
		word_t in_w);
		result_t res;
		logic [3:0] opc8;
		logic [3:0] opc3;
		word_t imm;
		logic [2:0] sh;
		opc8 = ins[11:8];
		opc3 = ins[7:4];
		imm = ins[7:0];
		sh = ins[2:0];
		res.wr = 1'b1;
		res.val = '0;
		if (opc8 != 4'hf)
		begin
			case (opc8)
				4'd0: res.val = a | imm;
				4'd1: res.val = a & imm;
				4'd2: res.val = a + m;
				4'd3: res.val = a - m;
				4'd4: res.val = a + imm;
				4'd5: res.val = a - imm;
				4'd6: res.val = imm;
				4'd7: res.val = m;
				4'd13: res.val = a | m;
				4'd14: res.val = a & m;
				default: res.wr = 1'b0; // branches, store, dropped codes
			endcase
		end
		else if (opc3 != 4'hf)
		begin
			case (opc3)
				4'd0, 4'd1: res.val = a << sh;
				4'd2: res.val = a >> sh;
				4'd3: res.val = $signed(a) >>> sh;
				4'd5: res.val = in_w;
				default: res.wr = 1'b0;
			endcase
		end
		else if (ins[3:0] == 4'd0)
			res.val = ~a;
		else
			res.wr = 1'b0;
		return res;
	endfunction

	// walk the program in order, one instruction at a time
	task automatic compute_expected();
		word_t acc;
		word_t outp;
		word_t mem[DMEM_SIZE];
		pc_t pc;
		result_t res;
		expect_t e;
		logic fop;
		acc = '0;
		outp = '0;
		pc = pc_t'(1); // first edge after reset steps past the reset nop
		for (int i = 0; i < n_instr; i++)
		begin
			fop = prog[i][12];
			res = ref_result(prog[i], fop ? fin[i + 2] : acc, mem[prog[i][4:0]], inp[i + 2]);
			if (prog[i][11:8] == 4'hf && prog[i][7:4] == 4'd8)
				outp = acc;
			if (prog[i][11:8] == 4'd11)
				mem[prog[i][4:0]] = fop ? fin[i + 1] : acc; // field latched one edge earlier
			if (res.wr && !fop)
				acc = res.val;
			if (prog[i][11:8] == 4'd8)
				pc = pc + pc_t'(prog[i][7:0]);
			else if (prog[i][11:8] == 4'd9)
				pc = pc - pc_t'(prog[i][7:0]);
			else
				pc = pc + pc_t'(1);
			e.acc = acc;
			e.outp = outp;
			e.fout = res.val;
			e.we = res.wr && fop;
			e.pc = pc;
			exp_q.push_back(e);
		end
	endtask

	task automatic check(string what, logic [31:0] exp_v, logic [31:0] act_v, int t);
		checks++;
		if (act_v !== exp_v)
		begin
			errors++;
			test_err[t]++;
			$display("Fail %s expected %0h actual %0h", what, exp_v, act_v);
		end
	endtask

	task automatic build_program();
		logic [31:0] r;
		cur_test = 0;
		for (int k = 0; k < 60; k++)
			push_alu(1'b0);
		cur_test = 1;
		for (int a = 0; a < DMEM_SIZE; a++)
		begin
			r = next_random();
			push_instr(encode_instr(1'b0, 4'd6, r[7:0]));
			push_instr(encode_instr(1'b0, 4'd11, {r[10:8], 5'(a)}));
			push_nop(); // store settles before any read
		end
		for (int k = 0; k < 40; k++)
		begin
			r = next_random();
			push_instr(encode_instr(1'b0, 4'd6, r[7:0]));
			push_instr(encode_instr(r[31], 4'd11, r[15:8]));
			push_nop();
			push_memop(1'b0);
		end
		cur_test = 2;
		for (int k = 0; k < 40; k++)
		begin
			r = next_random();
			if (r[1:0] == 2'd0)
				push_memop(1'b1);
			else if (r[1:0] == 2'd3)
				push_nop();
			else
				push_alu(r[0]);
		end
		cur_test = 3;
		for (int k = 0; k < 12; k++)
		begin
			r = next_random();
			push_instr(encode_instr(1'b0, 4'd6, r[7:0]));
			push_instr(encode_instr(1'b0, 4'hf, 8'h80)); // out
			push_alu(1'b0);
			push_instr(encode_instr(1'b0, 4'hf, 8'h80));
		end
		cur_test = 4;
		for (int k = 0; k < 20; k++)
		begin
			r = next_random();
			push_instr(encode_instr(1'b0, r[8] ? 4'd9 : 4'd8, r[7:0]));
			if (r[9])
				push_nop();
			else
				push_alu(1'b0);
		end
		n_instr = prog.size();
		for (int k = 0; k < n_instr + 2; k++)
		begin
			r = next_random();
			fin.push_back(r[7:0]);
			inp.push_back(r[15:8]);
		end
	endtask

	// ====================
	// stimulus
	// ====================
	initial
	begin
		seed = 32'h2e48;
		i_instruction = 20'h00fff;
		i_field_in = '0;
		i_inputs = '0;
		for (int t = 0; t < N_TESTS; t++)
			test_err[t] = 0;
		build_program();
		compute_expected();
		built = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		started = 1'b1;
		for (int j = 0; j < n_instr + 2; j++)
		begin
			if (j > 0)
				@(negedge clk);
			i_instruction = (j < n_instr) ? prog[j] : 20'h00fff;
			i_field_in = fin[j];
			i_inputs = inp[j];
		end
	end

	// compare two edges after each instruction
	initial
	begin
		int i;
		wait (started);
		@(posedge clk); // instr 0 registered
		for (int j = 1; j <= n_instr + 1; j++)
		begin
			@(posedge clk);
			@(negedge clk);
			if (j - 1 < n_instr)
			begin
				i = j - 1;
				check($sformatf("%s pc #%0d", tname[tst[i]], i), 32'(exp_q[i].pc), 32'(o_pc),
					tst[i]);
				check($sformatf("%s fieldp #%0d", tname[tst[i]], i), 32'(prog[i][19:15]),
					32'(o_fieldp), tst[i]);
				if (i >= FIELD_LATENCY)
					check($sformatf("%s fieldwp #%0d", tname[tst[i]], i),
						32'(prog[i - FIELD_LATENCY][19:15]), 32'(o_fieldwp), tst[i]);
			end
			if (j >= 2)
			begin
				i = j - 2;
				check($sformatf("%s acc #%0d", tname[tst[i]], i), 32'(exp_q[i].acc),
					32'(o_acc), tst[i]);
				check($sformatf("%s outputs #%0d", tname[tst[i]], i), 32'(exp_q[i].outp),
					32'(o_outputs), tst[i]);
				check($sformatf("%s write_en #%0d", tname[tst[i]], i), 32'(exp_q[i].we),
					32'(o_field_write_en), tst[i]);
				if (exp_q[i].we)
					check($sformatf("%s field_out #%0d", tname[tst[i]], i),
						32'(exp_q[i].fout), 32'(o_field_out), tst[i]);
				if (i == n_instr - 1 || tst[i + 1] != tst[i])
					$display("%s finished, %0d errors", tname[tst[i]], test_err[tst[i]]);
			end
		end
		$display("%0d instructions, %0d checks, %0d errors", n_instr, checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (built);
		#((n_instr + RESET_CYCLES + 50) * PERIOD);
		$display("watchdog expired before all checks finished");
		$display("Test failed");
		$finish;
	end

endmodule
